/* ex_cases.txt */
// op pc opr1 opr2 offset exp_data exc, all hex; exc is ov=4 adel=2 ades=1
// op follows the alu_op_e order, its name is in the trailing comment
04 00400000 7fffffff 00000001 00000000 80000000 4 // ADD overflow
05 00400004 ffffffff 00000002 00000000 00000001 0 // ADDU wraps
06 00400008 80000000 00000001 00000000 7fffffff 4 // SUB overflow
01 0040000c 00000004 000000f1 00000000 00000f10 0 // SLL
03 00400010 00000008 f0000000 00000000 fff00000 0 // SRA
02 00400014 00000008 f0000000 00000000 00f00000 0 // SRL
0b 00400018 0f0f0f0f 00ff00ff 00000000 f000f000 0 // NOR
0c 0040001c ffffffff 00000001 00000000 00000001 0 // SLT
0d 00400020 ffffffff 00000001 00000000 00000000 0 // SLTU
0f 00400024 00010000 00000000 00000000 0000000f 0 // CLZ
0e 00400028 ff000000 00000000 00000000 00000008 0 // CLO
10 00400030 00000000 00000000 00000000 00400038 0 // BAL
12 00400034 ffffffff ffffffff 00000000 00000000 0 // MULTU
17 00400038 00000000 00000000 00000000 fffffffe 0 // MFHI
18 0040003c 00000000 00000000 00000000 00000001 0 // MFLO
11 00400040 fffffffe 00000003 00000000 00000000 0 // MULT
13 00400044 00010000 00010000 00000000 00000000 0 // MADD
15 00400048 00000002 00000003 00000000 00000000 0 // MSUB
17 0040004c 00000000 00000000 00000000 00000000 0 // MFHI
18 00400050 00000000 00000000 00000000 fffffff4 0 // MFLO
19 00400054 fffffff9 00000002 00000000 00000000 0 // DIV
18 00400058 00000000 00000000 00000000 fffffffd 0 // MFLO
17 0040005c 00000000 00000000 00000000 ffffffff 0 // MFHI
1a 00400060 00000064 00000000 00000000 00000000 0 // DIVU by zero
18 00400064 00000000 00000000 00000000 ffffffff 0 // MFLO
17 00400068 00000000 00000000 00000000 00000064 0 // MFHI
22 0040006c 00000100 a1b2c3d4 00000000 00000000 0 // SW
20 00400070 00000100 000000e5 00000001 00000000 0 // SB
21 00400074 00000100 00008765 00000002 00000000 0 // SH
1f 00400078 00000100 00000000 00000000 8765e5d4 0 // LW
1b 0040007c 00000100 00000000 00000001 ffffffe5 0 // LB
1c 00400080 00000100 00000000 00000001 000000e5 0 // LBU
1d 00400084 00000100 00000000 00000002 ffff8765 0 // LH
1e 00400088 00000100 00000000 00000000 0000e5d4 0 // LHU
1d 0040008c 00000100 00000000 00000001 00000000 2 // LH misaligned
1f 00400090 00000100 00000000 00000002 00000000 2 // LW misaligned
22 00400094 00000100 deadbeef 00000002 00000000 1 // SW misaligned
21 00400098 00000100 00001234 00000001 00000000 1 // SH misaligned
1f 0040009c 00000108 00000000 fffffff8 8765e5d4 0 // LW negative offset

/* sources.f */
+incdir+.
ex_pkg.sv
ex_alu.sv
ex_hilo.sv
ex_div.sv
ex_dmem.sv
ex_top.sv
ex_chk.sv
ex_clk_gen.sv
ex_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module ex_tb -f sources.f -o ex_tb_sim
./obj_dir/ex_tb_sim

/* ex_tb.sv */
`timescale 1ns/100ps
`include "ex_consts.svh"

module ex_tb;
    localparam int MAX_CASES = 64;
    localparam int COLS      = 7;
    localparam int N_RAND    = 24;
    localparam int RST_CYC   = 16;

    // Outstanding result and the cycle it is due in
    typedef struct packed {
        ex_pkg::alu_op_e op;
        ex_pkg::ex_res_t res;
        logic [31:0]     due;
    } pending_t;

    logic            clk;
    logic            arst_n;
    logic            issue;
    ex_pkg::ex_req_t req;
    ex_pkg::ex_res_t res;
    logic            res_valid;
    logic            stall;

    logic [31:0]     case_mem [MAX_CASES*COLS];
    ex_pkg::ex_req_t stim_q [$];
    ex_pkg::ex_res_t want_q [$];
    pending_t        pend_q [$];
    int              cycles = 0;
    int              cycle_limit = 0;

    ex_clk_gen #(.PERIOD_NS(20)) u_clk_gen (.clk_o(clk));

    ex_top dut_i (
        .clk         (clk),
        .arst_n_i    (arst_n),
        .issue_i     (issue),
        .req_i       (req),
        .res_o       (res),
        .res_valid_o (res_valid),
        .stall_o     (stall)
    );

    bind ex_top ex_chk u_chk (
        .clk_i       (clk),
        .arst_n_i    (arst_n_i),
        .issue_i     (issue_i),
        .stall_i     (stall_o),
        .res_valid_i (res_valid_o)
    );

    task automatic end_with_failure();
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic check_exc(input ex_pkg::exc_t got, input ex_pkg::exc_t want,
                             input ex_pkg::alu_op_e op);
        if (got !== want) begin
            $display("Mismatch at %0t: %s flags ov/adel/ades %03b, expected %03b",
                     $time, op.name(), got, want);
            end_with_failure();
        end
    endtask

    task automatic check_res(input ex_pkg::ex_res_t got, input pending_t want);
        ex_pkg::alu_op_e op;
        op = want.op;
        if (got.data !== want.res.data) begin
            $display("Mismatch at %0t: %s data %08h, expected %08h",
                     $time, op.name(), got.data, want.res.data);
            end_with_failure();
        end
        if (got.load !== want.res.load) begin
            $display("Mismatch at %0t: %s load flag %b, expected %b",
                     $time, op.name(), got.load, want.res.load);
            end_with_failure();
        end
        if (cycles != want.due) begin
            $display("Mismatch at %0t: %s result in cycle %0d, expected cycle %0d",
                     $time, op.name(), cycles, want.due);
            end_with_failure();
        end
        check_exc(got.exc, want.res.exc, op);
    endtask

    function automatic logic is_load(input ex_pkg::alu_op_e op);
        return op inside {ex_pkg::OP_LB, ex_pkg::OP_LBU, ex_pkg::OP_LH,
                          ex_pkg::OP_LHU, ex_pkg::OP_LW};
    endfunction

    function automatic logic is_div(input ex_pkg::alu_op_e op);
        return (op == ex_pkg::OP_DIV) || (op == ex_pkg::OP_DIVU);
    endfunction

    // Reference for the single-cycle ALU operations
    function automatic ex_pkg::ex_res_t model_alu(input ex_pkg::ex_req_t r);
        ex_pkg::ex_res_t e;
        logic [32:0]     wide;
        logic [63:0]     ext;
        logic [4:0]      sh;
        logic            lead;
        int              n;
        e  = '0;
        sh = r.opr1[4:0];
        case (r.op)
            ex_pkg::OP_SLL: e.data = r.opr2 << sh;
            ex_pkg::OP_SRL: e.data = r.opr2 >> sh;
            ex_pkg::OP_SRA: begin
                ext    = {{32{r.opr2[31]}}, r.opr2} >> sh;
                e.data = ext[31:0];
            end
            ex_pkg::OP_ADD, ex_pkg::OP_ADDU: begin
                wide     = {r.opr1[31], r.opr1} + {r.opr2[31], r.opr2};
                e.data   = wide[31:0];
                e.exc.ov = (r.op == ex_pkg::OP_ADD) && (wide[32] != wide[31]);
            end
            ex_pkg::OP_SUB, ex_pkg::OP_SUBU: begin
                wide     = {r.opr1[31], r.opr1} - {r.opr2[31], r.opr2};
                e.data   = wide[31:0];
                e.exc.ov = (r.op == ex_pkg::OP_SUB) && (wide[32] != wide[31]);
            end
            ex_pkg::OP_AND: e.data = r.opr1 & r.opr2;
            ex_pkg::OP_OR:  e.data = r.opr1 | r.opr2;
            ex_pkg::OP_XOR: e.data = r.opr1 ^ r.opr2;
            ex_pkg::OP_NOR: e.data = ~(r.opr1 | r.opr2);
            // Flipping the sign bit turns signed order into unsigned order
            ex_pkg::OP_SLT: e.data = {31'b0, (r.opr1 ^ 32'h8000_0000) < (r.opr2 ^ 32'h8000_0000)};
            ex_pkg::OP_SLTU: e.data = {31'b0, r.opr1 < r.opr2};
            ex_pkg::OP_CLO, ex_pkg::OP_CLZ: begin
                lead = (r.op == ex_pkg::OP_CLO);
                n    = 0;
                for (int i = 31; i >= 0; i--) begin
                    if (r.opr1[i] != lead) break;
                    n++;
                end
                e.data = n;
            end
            ex_pkg::OP_BAL: e.data = r.pc + 32'd8;
            default: e.data = '0;
        endcase
        return e;
    endfunction

    initial begin
        ex_pkg::ex_req_t r;
        ex_pkg::ex_res_t e;
        pending_t        p;
        int              idx;
        int              pos;
        logic            div_wait;

        issue  = 1'b0;
        req    = '0;
        arst_n = 1'b0;
        void'($urandom(39));

        for (int i = 0; i < MAX_CASES*COLS; i++) begin
            case_mem[i] = '1;
        end
        $readmemh("ex_cases.txt", case_mem);

        idx = 0;
        while (idx < MAX_CASES && case_mem[idx*COLS] != '1) begin
            r.op     = ex_pkg::alu_op_e'(case_mem[idx*COLS][5:0]);
            r.pc     = case_mem[idx*COLS+1];
            r.opr1   = case_mem[idx*COLS+2];
            r.opr2   = case_mem[idx*COLS+3];
            r.offset = case_mem[idx*COLS+4];
            e.data   = case_mem[idx*COLS+5];
            e.exc    = case_mem[idx*COLS+6][2:0];
            e.load   = is_load(r.op) && !e.exc.adel;
            stim_q.push_back(r);
            want_q.push_back(e);
            idx++;
        end
        if (idx == 0) begin
            $display("No cases could be read from ex_cases.txt");
            end_with_failure();
        end

        // Random ALU operations from SLL through BAL
        repeat (N_RAND) begin
            r.op     = ex_pkg::alu_op_e'(6'(1 + $urandom_range(15)));
            r.pc     = $urandom() & 32'hffff_fffc;
            r.opr1   = $urandom() >> $urandom_range(31);
            r.opr2   = $urandom();
            r.offset = '0;
            stim_q.push_back(r);
            want_q.push_back(model_alu(r));
        end
        cycle_limit = stim_q.size() * (`EX_DIV_STEPS + 4) + 100;

        repeat (RST_CYC) @(negedge clk);
        arst_n = 1'b1;

        pos      = 0;
        div_wait = 1'b0;
        while (pos < stim_q.size() || pend_q.size() != 0 || stall || div_wait) begin
            @(negedge clk);
            if (div_wait && !stall) begin
                $display("stall_o stayed low after a divide was issued");
                end_with_failure();
            end
            div_wait = 1'b0;
            if (res_valid) begin
                if (pend_q.size() == 0) begin
                    $display("res_valid_o pulsed with no operation outstanding");
                    end_with_failure();
                end else begin
                    check_res(res, pend_q.pop_front());
                end
            end
            issue = 1'b0;
            req   = '0;
            if (!stall && pos < stim_q.size()) begin
                req   = stim_q[pos];
                issue = 1'b1;
                if (is_div(req.op)) begin
                    div_wait = 1'b1;
                end else begin
                    p.op  = req.op;
                    p.res = want_q[pos];
                    p.due = cycles + 3;
                    pend_q.push_back(p);
                end
                pos++;
            end
        end

        // No stray results once everything has drained
        repeat (3) begin
            @(negedge clk);
            if (res_valid) begin
                $display("res_valid_o pulsed after the last operation");
                end_with_failure();
            end
        end

        $display("Result: PASSED");
        $finish;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            end_with_failure();
        end
    end

endmodule

/* ex_clk_gen.sv */
`timescale 1ns/100ps

module ex_clk_gen #(
    parameter int PERIOD_NS = 20
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

endmodule

/* ex_chk.sv */
`timescale 1ns/100ps
`include "ex_consts.svh"

module ex_chk (
    input logic clk_i,
    input logic arst_n_i,
    input logic issue_i,
    input logic stall_i,
    input logic res_valid_i
);
    int unsigned stall_run;

    // Consecutive cycles with stall high
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            stall_run <= 0;
        end else if (stall_i) begin
            stall_run <= stall_run + 1;
        end else begin
            stall_run <= 0;
        end
    end

    res_quiet_in_reset: assert property (@(posedge clk_i) !arst_n_i |-> res_valid_i !== 1'b1)
        else $error("res_valid_o high while reset is asserted");

    no_issue_in_stall: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !(issue_i && stall_i))
        else $error("issue_i high while stall_o is high");

    stall_bounded: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        stall_run <= `EX_DIV_STEPS + 3)
        else $error("stall_o held longer than a divide takes");

endmodule

/* ex_top.sv */
`timescale 1ns/100ps
`include "ex_consts.svh"

module ex_top (
    input  logic            clk,
    input  logic            arst_n_i,
    input  logic            issue_i,
    input  ex_pkg::ex_req_t req_i,
    output ex_pkg::ex_res_t res_o,
    output logic            res_valid_o,
    output logic            stall_o
);
    ex_pkg::ex_req_t     req_q;
    ex_pkg::ex_res_t     alu_res, res_d;
    ex_pkg::mem_req_t    mem_req;
    ex_pkg::mul_pp_t     pp;
    logic                valid_q, valid_d;
    logic                div_start, div_signed, div_busy, div_done;
    logic [`EX_XLEN-1:0] div_a, div_b, quot, rem, hi, lo, rdata;

    assign stall_o = div_start | div_busy;

    // Idle cycles execute as NOP so nothing fires twice
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            req_q   <= '0;
            valid_q <= 1'b0;
        end else if (issue_i && !stall_o) begin
            req_q   <= req_i;
            valid_q <= 1'b1;
        end else begin
            req_q   <= '0;
            valid_q <= 1'b0;
        end
    end

    // Divides report through stall only
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_d     <= 1'b0;
            res_valid_o <= 1'b0;
        end else begin
            valid_d     <= valid_q & ~div_start;
            res_valid_o <= valid_d;
        end
    end

    always_ff @(posedge clk) begin
        res_d <= alu_res;
        res_o <= res_d;
        if (res_d.load) begin
            res_o.data <= rdata;
        end
    end

    ex_alu u_alu (
        .req_i        (req_q),
        .hi_i         (hi),
        .lo_i         (lo),
        .res_o        (alu_res),
        .mem_o        (mem_req),
        .pp_o         (pp),
        .div_start_o  (div_start),
        .div_signed_o (div_signed),
        .div_a_o      (div_a),
        .div_b_o      (div_b)
    );

    ex_hilo u_hilo (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .op_i       (req_q.op),
        .pp_i       (pp),
        .div_done_i (div_done),
        .quot_i     (quot),
        .rem_i      (rem),
        .hi_o       (hi),
        .lo_o       (lo)
    );

    ex_div u_div (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .start_i  (div_start),
        .signed_i (div_signed),
        .a_i      (div_a),
        .b_i      (div_b),
        .busy_o   (div_busy),
        .done_o   (div_done),
        .quot_o   (quot),
        .rem_o    (rem)
    );

    ex_dmem u_dmem (
        .clk     (clk),
        .mem_i   (mem_req),
        .rdata_o (rdata)
    );

endmodule

/* ex_dmem.sv */
`timescale 1ns/100ps
`include "ex_consts.svh"

module ex_dmem (
    input  logic                clk,
    input  ex_pkg::mem_req_t    mem_i,
    output logic [`EX_XLEN-1:0] rdata_o
);
    localparam int AW = $clog2(`EX_DMEM_WORDS);

    logic [`EX_XLEN-1:0] ram [`EX_DMEM_WORDS];
    logic [AW-1:0]       idx;
    logic [`EX_XLEN-1:0] word_q;
    logic [1:0]          ofs_q;
    ex_pkg::alu_op_e     kind_q;
    logic [7:0]          byte_sel;
    logic [15:0]         half_sel;

    assign idx = mem_i.addr[AW+1:2];

    always_ff @(posedge clk) begin
        if (mem_i.en) begin
            for (int i = 0; i < `EX_BE_W; i++) begin
                if (mem_i.wen[i]) begin
                    ram[idx][8*i +: 8] <= mem_i.wdata[8*i +: 8];
                end
            end
            word_q <= ram[idx];
            ofs_q  <= mem_i.addr[1:0];
            kind_q <= mem_i.kind;
        end
    end

    // Lane select and extension
    assign byte_sel = word_q[8*ofs_q +: 8];
    assign half_sel = ofs_q[1] ? word_q[31:16] : word_q[15:0];

    always_comb begin
        case (kind_q)
            ex_pkg::OP_LB:  rdata_o = {{24{byte_sel[7]}}, byte_sel};
            ex_pkg::OP_LBU: rdata_o = {24'b0, byte_sel};
            ex_pkg::OP_LH:  rdata_o = {{16{half_sel[15]}}, half_sel};
            ex_pkg::OP_LHU: rdata_o = {16'b0, half_sel};
            default:        rdata_o = word_q;
        endcase
    end

endmodule

/* ex_div.sv */
`timescale 1ns/100ps
`include "ex_consts.svh"

module ex_div (
    input  logic                clk,
    input  logic                arst_n_i,
    input  logic                start_i,
    input  logic                signed_i,
    input  logic [`EX_XLEN-1:0] a_i,
    input  logic [`EX_XLEN-1:0] b_i,
    output logic                busy_o,
    output logic                done_o,
    output logic [`EX_XLEN-1:0] quot_o,
    output logic [`EX_XLEN-1:0] rem_o
);
    localparam int W  = `EX_XLEN;
    localparam int CW = $clog2(`EX_DIV_STEPS);

    ex_pkg::div_state_e state;
    logic [CW-1:0]      cnt;
    logic [W-1:0]       q, r, dvs;
    logic [W:0]         r_sh, r_diff;
    logic               a_neg, b_neg, neg_q, neg_r, b_zero;

    assign a_neg  = signed_i & a_i[W-1];
    assign b_neg  = signed_i & b_i[W-1];
    assign r_sh   = {r, q[W-1]};
    assign r_diff = r_sh - {1'b0, dvs};

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state <= ex_pkg::IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                ex_pkg::IDLE: begin
                    cnt <= '0;
                    if (start_i) begin
                        state <= ex_pkg::RUN;
                    end
                end
                ex_pkg::RUN: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CW'(`EX_DIV_STEPS - 1)) begin
                        state <= ex_pkg::FIX;
                    end
                end
                default: state <= ex_pkg::IDLE;
            endcase
        end
    end

    // q starts as the dividend magnitude and fills with quotient bits
    always_ff @(posedge clk) begin
        if (state == ex_pkg::IDLE && start_i) begin
            q      <= a_neg ? -a_i : a_i;
            dvs    <= b_neg ? -b_i : b_i;
            r      <= '0;
            neg_q  <= a_neg ^ b_neg;
            neg_r  <= a_neg;
            b_zero <= (b_i == '0);
        end else if (state == ex_pkg::RUN) begin
            r <= r_diff[W] ? r_sh[W-1:0] : r_diff[W-1:0];
            q <= {q[W-2:0], ~r_diff[W]};
        end
    end

    assign busy_o = (state != ex_pkg::IDLE);
    assign done_o = (state == ex_pkg::FIX);
    assign quot_o = b_zero ? '1 : (neg_q ? -q : q);
    assign rem_o  = neg_r ? -r : r;

endmodule

/* ex_hilo.sv */
`timescale 1ns/100ps
`include "ex_consts.svh"

module ex_hilo (
    input  logic                clk,
    input  logic                arst_n_i,
    input  ex_pkg::alu_op_e     op_i,
    input  ex_pkg::mul_pp_t     pp_i,
    input  logic                div_done_i,
    input  logic [`EX_XLEN-1:0] quot_i,
    input  logic [`EX_XLEN-1:0] rem_i,
    output logic [`EX_XLEN-1:0] hi_o,
    output logic [`EX_XLEN-1:0] lo_o
);
    localparam int W = `EX_XLEN;
    localparam int H = W / 2;

    logic [2*W-1:0] mag, prod, acc;

    // Cross terms land half a word up
    assign mag = {{W{1'b0}}, pp_i.pp[0]}
               + {{H{1'b0}}, pp_i.pp[1], {H{1'b0}}}
               + {{H{1'b0}}, pp_i.pp[2], {H{1'b0}}}
               + {pp_i.pp[3], {W{1'b0}}};
    assign prod = pp_i.neg ? -mag : mag;
    assign acc  = {hi_o, lo_o};

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            hi_o <= '0;
            lo_o <= '0;
        end else if (div_done_i) begin
            hi_o <= rem_i;
            lo_o <= quot_i;
        end else begin
            case (op_i)
                ex_pkg::OP_MULT, ex_pkg::OP_MULTU: {hi_o, lo_o} <= prod;
                ex_pkg::OP_MADD, ex_pkg::OP_MADDU: {hi_o, lo_o} <= acc + prod;
                ex_pkg::OP_MSUB, ex_pkg::OP_MSUBU: {hi_o, lo_o} <= acc - prod;
                default: begin
                    hi_o <= hi_o;
                    lo_o <= lo_o;
                end
            endcase
        end
    end

endmodule

/* ex_alu.sv */
`timescale 1ns/100ps
`include "ex_consts.svh"

module ex_alu (
    input  ex_pkg::ex_req_t     req_i,
    input  logic [`EX_XLEN-1:0] hi_i,
    input  logic [`EX_XLEN-1:0] lo_i,
    output ex_pkg::ex_res_t     res_o,
    output ex_pkg::mem_req_t    mem_o,
    output ex_pkg::mul_pp_t     pp_o,
    output logic                div_start_o,
    output logic                div_signed_o,
    output logic [`EX_XLEN-1:0] div_a_o,
    output logic [`EX_XLEN-1:0] div_b_o
);
    localparam int W = `EX_XLEN;

    logic [W-1:0] a, b, sum, diff, ea, abs_a, abs_b, mop_a, mop_b;
    logic         a_s, b_s, adel, ades, is_load;
    logic [W-1:0] clz_in;
    logic [15:0]  x16;
    logic [7:0]   x8;
    logic [3:0]   x4;
    logic [1:0]   x2;
    logic [4:0]   nz;
    logic [5:0]   clz_n;

    assign a     = req_i.opr1;
    assign b     = req_i.opr2;
    assign a_s   = a[W-1];
    assign b_s   = b[W-1];
    assign sum   = a + b;
    assign diff  = a - b;
    assign ea    = a + req_i.offset;
    assign abs_a = a_s ? -a : a;
    assign abs_b = b_s ? -b : b;

    // Leading zero count by halving
    // CLO counts the zeros of the inverted operand
    assign clz_in = (req_i.op == ex_pkg::OP_CLO) ? ~a : a;
    assign nz[4]  = ~|clz_in[31:16];
    assign x16    = nz[4] ? clz_in[15:0] : clz_in[31:16];
    assign nz[3]  = ~|x16[15:8];
    assign x8     = nz[3] ? x16[7:0] : x16[15:8];
    assign nz[2]  = ~|x8[7:4];
    assign x4     = nz[2] ? x8[3:0] : x8[7:4];
    assign nz[1]  = ~|x4[3:2];
    assign x2     = nz[1] ? x4[1:0] : x4[3:2];
    assign nz[0]  = ~x2[1];
    assign clz_n  = (clz_in == '0) ? 6'd32 : {1'b0, nz};

    assign div_start_o  = (req_i.op == ex_pkg::OP_DIV) || (req_i.op == ex_pkg::OP_DIVU);
    assign div_signed_o = (req_i.op == ex_pkg::OP_DIV);
    assign div_a_o      = a;
    assign div_b_o      = b;

    // Multiply on magnitudes with the sign restored in HI/LO
    always_comb begin
        pp_o = '0;
        case (req_i.op)
            ex_pkg::OP_MULT, ex_pkg::OP_MADD, ex_pkg::OP_MSUB: begin
                mop_a    = abs_a;
                mop_b    = abs_b;
                pp_o.neg = a_s ^ b_s;
            end
            ex_pkg::OP_MULTU, ex_pkg::OP_MADDU, ex_pkg::OP_MSUBU: begin
                mop_a = a;
                mop_b = b;
            end
            default: begin
                mop_a = '0;
                mop_b = '0;
            end
        endcase
        pp_o.pp[0] = {16'b0, mop_a[15:0]} * {16'b0, mop_b[15:0]};
        pp_o.pp[1] = {16'b0, mop_a[31:16]} * {16'b0, mop_b[15:0]};
        pp_o.pp[2] = {16'b0, mop_a[15:0]} * {16'b0, mop_b[31:16]};
        pp_o.pp[3] = {16'b0, mop_a[31:16]} * {16'b0, mop_b[31:16]};
    end

    always_comb begin
        mem_o      = '0;
        mem_o.addr = ea;
        mem_o.kind = req_i.op;
        adel       = 1'b0;
        ades       = 1'b0;
        is_load    = 1'b1;
        case (req_i.op)
            ex_pkg::OP_LB, ex_pkg::OP_LBU: adel = 1'b0;
            ex_pkg::OP_LH, ex_pkg::OP_LHU: adel = ea[0];
            ex_pkg::OP_LW:                 adel = |ea[1:0];
            ex_pkg::OP_SB: begin
                is_load     = 1'b0;
                mem_o.wdata = {4{b[7:0]}};
                mem_o.wen   = 4'b0001 << ea[1:0];
            end
            ex_pkg::OP_SH: begin
                is_load     = 1'b0;
                ades        = ea[0];
                mem_o.wdata = {2{b[15:0]}};
                mem_o.wen   = ea[1] ? 4'b1100 : 4'b0011;
            end
            ex_pkg::OP_SW: begin
                is_load     = 1'b0;
                ades        = |ea[1:0];
                mem_o.wdata = b;
                mem_o.wen   = 4'b1111;
            end
            default: is_load = 1'b0;
        endcase
        // Misaligned access never reaches the RAM
        mem_o.en = (is_load || (mem_o.wen != '0)) && !adel && !ades;
        if (!mem_o.en) begin
            mem_o.wen = '0;
        end
    end

    always_comb begin
        res_o = '0;
        case (req_i.op)
            ex_pkg::OP_SLL:  res_o.data = b << a[4:0];
            ex_pkg::OP_SRL:  res_o.data = b >> a[4:0];
            ex_pkg::OP_SRA:  res_o.data = $signed(b) >>> a[4:0];
            ex_pkg::OP_ADD, ex_pkg::OP_ADDU: res_o.data = sum;
            ex_pkg::OP_SUB, ex_pkg::OP_SUBU: res_o.data = diff;
            ex_pkg::OP_AND:  res_o.data = a & b;
            ex_pkg::OP_OR:   res_o.data = a | b;
            ex_pkg::OP_XOR:  res_o.data = a ^ b;
            ex_pkg::OP_NOR:  res_o.data = ~(a | b);
            ex_pkg::OP_SLT:  res_o.data = {31'b0, $signed(a) < $signed(b)};
            ex_pkg::OP_SLTU: res_o.data = {31'b0, a < b};
            ex_pkg::OP_CLO, ex_pkg::OP_CLZ: res_o.data = {26'b0, clz_n};
            ex_pkg::OP_BAL:  res_o.data = req_i.pc + `EX_LINK_OFS;
            ex_pkg::OP_MFHI: res_o.data = hi_i;
            ex_pkg::OP_MFLO: res_o.data = lo_i;
            default:         res_o.data = '0;
        endcase
        res_o.exc.ov   = ((req_i.op == ex_pkg::OP_ADD) && !(a_s ^ b_s) && (sum[W-1] ^ a_s))
                      || ((req_i.op == ex_pkg::OP_SUB) && (a_s ^ b_s) && (diff[W-1] ^ a_s));
        res_o.exc.adel = adel;
        res_o.exc.ades = ades;
        res_o.load     = is_load && mem_o.en;
    end

endmodule

/* ex_pkg.sv */
`include "ex_consts.svh"

package ex_pkg;

    typedef enum logic [`EX_OP_W-1:0] {
        OP_NOP,
        OP_SLL, OP_SRL, OP_SRA,
        OP_ADD, OP_ADDU, OP_SUB, OP_SUBU,
        OP_AND, OP_OR, OP_XOR, OP_NOR,
        OP_SLT, OP_SLTU, OP_CLO, OP_CLZ, OP_BAL,
        OP_MULT, OP_MULTU, OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU,
        OP_MFHI, OP_MFLO, OP_DIV, OP_DIVU,
        OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW,
        OP_SB, OP_SH, OP_SW
    } alu_op_e;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        FIX
    } div_state_e;

    typedef struct packed {
        alu_op_e             op;
        logic [`EX_XLEN-1:0] pc;
        logic [`EX_XLEN-1:0] opr1;
        logic [`EX_XLEN-1:0] opr2;
        logic [`EX_XLEN-1:0] offset;
    } ex_req_t;

    typedef struct packed {
        logic ov;
        logic adel;
        logic ades;
    } exc_t;

    typedef struct packed {
        logic [`EX_XLEN-1:0] data;
        exc_t                exc;
        logic                load;
    } ex_res_t;

    typedef struct packed {
        logic                en;
        logic [`EX_BE_W-1:0] wen;
        logic [`EX_XLEN-1:0] addr;
        logic [`EX_XLEN-1:0] wdata;
        alu_op_e             kind;
    } mem_req_t;

    // pp[0] lo*lo, pp[1] hi*lo, pp[2] lo*hi, pp[3] hi*hi
    typedef struct packed {
        logic [3:0][`EX_XLEN-1:0] pp;
        logic                     neg;
    } mul_pp_t;

endpackage

/* ex_consts.svh */
`ifndef EX_CONSTS_SVH
`define EX_CONSTS_SVH

// Datapath width
`define EX_XLEN 32

// Byte lanes in one data word
`define EX_BE_W (`EX_XLEN / 8)

// Opcode field width
`define EX_OP_W 6

// Data RAM depth in words
`define EX_DMEM_WORDS 256

// Divider iterations with one quotient bit per step
`define EX_DIV_STEPS 32

// Link address skips the branch and its delay slot
`define EX_LINK_OFS 32'd8

`endif
